/* hw/rv_exec_config.svh */
`ifndef RV_EXEC_CONFIG_SVH
`define RV_EXEC_CONFIG_SVH

// Core data width, one machine word
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_NREGS 32

// Register index width
`define RV_REG_AW 5

`endif

/* hw/rv_exec_pkg.sv */
`default_nettype none
`include "rv_exec_config.svh"

package rv_exec_pkg;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;   // Upper 7 bits double as shift funct
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;     // Sign bit
        logic [5:0]            imm_10_5;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm_20;     // Sign bit
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    // One instruction word, six views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef enum logic [3:0] {
        it_op, it_opimm, it_load, it_store, it_branch,
        it_lui, it_auipc, it_jal, it_jalr, it_nop   // it_nop flags illegal
    } itype_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_xor, alu_or, alu_and,
        alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu, no_alu
    } alu_func_e;

    typedef enum logic [2:0] {
        br_eq, br_neq, br_lt, br_ge, br_ltu, br_geu, no_br
    } br_func_e;

    typedef struct packed {
        itype_e                itype;
        alu_func_e             alu_func;
        br_func_e              br_func;
        logic [`RV_XLEN-1:0]   imm;        // Already sign extended
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
        logic                  wr;         // Class writes rd
    } decoded_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        instr_u              instr;
    } issue_req_t;

    typedef struct packed {
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   value;
        logic                  wr;
        logic                  taken;
        logic [`RV_XLEN-1:0]   next_pc;
        logic                  illegal;
    } exec_result_t;

endpackage

`default_nettype wire

/* hw/decode.sv */
`default_nettype none
`include "rv_exec_config.svh"

module decode (
    input  wire rv_exec_pkg::instr_u instr,
    output rv_exec_pkg::decoded_t    dec
);

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_opimm  = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

    logic [2:0]             f3;
    logic [6:0]             f7;
    logic [6:0]             shift_hi;   // imm[11:5] of I format
    logic [`RV_XLEN-1:0]    imm_i;
    logic [`RV_XLEN-1:0]    imm_s;
    logic [`RV_XLEN-1:0]    imm_b;
    logic [`RV_XLEN-1:0]    imm_u;
    logic [`RV_XLEN-1:0]    imm_j;
    rv_exec_pkg::alu_func_e alu_r;
    rv_exec_pkg::alu_func_e alu_i;
    rv_exec_pkg::br_func_e  br_f;

    assign f3       = instr.r_fmt.funct3;                    // Same slot in every format
    assign f7       = instr.r_fmt.funct7;
    assign shift_hi = instr.i_fmt.imm_11_0[11:5];

    assign imm_i = {{(`RV_XLEN-12){instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
    assign imm_s = {{(`RV_XLEN-12){instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                    instr.s_fmt.imm_4_0};
    assign imm_b = {{(`RV_XLEN-12){instr.b_fmt.imm_12}}, instr.b_fmt.imm_11,
                    instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};  // Halfword aligned
    assign imm_u = {instr.u_fmt.imm_31_12, 12'b0};           // Upper 20, low zeroed
    assign imm_j = {{(`RV_XLEN-20){instr.j_fmt.imm_20}}, instr.j_fmt.imm_19_12,
                    instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};

    always_comb begin                                        // Register-register ALU op
        case ({f7, f3})
            {7'h00, 3'h0}: alu_r = rv_exec_pkg::alu_add;
            {7'h20, 3'h0}: alu_r = rv_exec_pkg::alu_sub;
            {7'h00, 3'h4}: alu_r = rv_exec_pkg::alu_xor;
            {7'h00, 3'h6}: alu_r = rv_exec_pkg::alu_or;
            {7'h00, 3'h7}: alu_r = rv_exec_pkg::alu_and;
            {7'h00, 3'h1}: alu_r = rv_exec_pkg::alu_sll;
            {7'h00, 3'h5}: alu_r = rv_exec_pkg::alu_srl;
            {7'h20, 3'h5}: alu_r = rv_exec_pkg::alu_sra;
            {7'h00, 3'h2}: alu_r = rv_exec_pkg::alu_slt;
            {7'h00, 3'h3}: alu_r = rv_exec_pkg::alu_sltu;
            default:       alu_r = rv_exec_pkg::no_alu;      // Unknown funct pair
        endcase
    end

    always_comb begin                                        // Immediate ALU op
        case (f3)
            3'h0: alu_i = rv_exec_pkg::alu_add;
            3'h4: alu_i = rv_exec_pkg::alu_xor;
            3'h6: alu_i = rv_exec_pkg::alu_or;
            3'h7: alu_i = rv_exec_pkg::alu_and;
            3'h2: alu_i = rv_exec_pkg::alu_slt;
            3'h3: alu_i = rv_exec_pkg::alu_sltu;
            3'h1: alu_i = (shift_hi == 7'h00) ? rv_exec_pkg::alu_sll : rv_exec_pkg::no_alu;
            default: begin                                   // funct3 5, right shifts
                if (shift_hi == 7'h00)
                    alu_i = rv_exec_pkg::alu_srl;
                else if (shift_hi == 7'h20)
                    alu_i = rv_exec_pkg::alu_sra;            // 0x20 picks arithmetic
                else
                    alu_i = rv_exec_pkg::no_alu;
            end
        endcase
    end

    always_comb begin                                        // Branch compare from funct3
        case (f3)
            3'h0:    br_f = rv_exec_pkg::br_eq;
            3'h1:    br_f = rv_exec_pkg::br_neq;
            3'h4:    br_f = rv_exec_pkg::br_lt;
            3'h5:    br_f = rv_exec_pkg::br_ge;
            3'h6:    br_f = rv_exec_pkg::br_ltu;
            3'h7:    br_f = rv_exec_pkg::br_geu;
            default: br_f = rv_exec_pkg::no_br;
        endcase
    end

    always_comb begin
        dec          = '0;
        dec.itype    = rv_exec_pkg::it_nop;                  // Illegal unless matched
        dec.alu_func = rv_exec_pkg::no_alu;
        dec.br_func  = rv_exec_pkg::no_br;
        case (instr.r_fmt.opcode)
            opc_op: if (alu_r != rv_exec_pkg::no_alu) begin
                dec.itype    = rv_exec_pkg::it_op;
                dec.alu_func = alu_r;
                dec.rs1      = instr.r_fmt.rs1;
                dec.rs2      = instr.r_fmt.rs2;
                dec.rd       = instr.r_fmt.rd;
                dec.wr       = 1'b1;
            end
            opc_opimm: if (alu_i != rv_exec_pkg::no_alu) begin
                dec.itype    = rv_exec_pkg::it_opimm;
                dec.alu_func = alu_i;
                dec.imm      = imm_i;
                dec.rs1      = instr.i_fmt.rs1;
                dec.rd       = instr.i_fmt.rd;
                dec.wr       = 1'b1;
            end
            opc_load: if (f3 == 3'b010) begin                // Word size only
                dec.itype    = rv_exec_pkg::it_load;
                dec.alu_func = rv_exec_pkg::alu_add;         // Address only
                dec.imm      = imm_i;
                dec.rs1      = instr.i_fmt.rs1;
                dec.rd       = instr.i_fmt.rd;
            end
            opc_store: if (f3 == 3'b010) begin
                dec.itype    = rv_exec_pkg::it_store;
                dec.alu_func = rv_exec_pkg::alu_add;
                dec.imm      = imm_s;
                dec.rs1      = instr.s_fmt.rs1;
                dec.rs2      = instr.s_fmt.rs2;
            end
            opc_branch: if (br_f != rv_exec_pkg::no_br) begin
                dec.itype   = rv_exec_pkg::it_branch;
                dec.br_func = br_f;
                dec.imm     = imm_b;
                dec.rs1     = instr.b_fmt.rs1;
                dec.rs2     = instr.b_fmt.rs2;
            end
            opc_lui, opc_auipc: begin
                dec.itype = (instr.u_fmt.opcode == opc_lui) ? rv_exec_pkg::it_lui
                                                            : rv_exec_pkg::it_auipc;
                dec.imm   = imm_u;
                dec.rd    = instr.u_fmt.rd;
                dec.wr    = 1'b1;
            end
            opc_jal: begin
                dec.itype = rv_exec_pkg::it_jal;
                dec.imm   = imm_j;
                dec.rd    = instr.j_fmt.rd;
                dec.wr    = 1'b1;
            end
            opc_jalr: if (f3 == 3'b000) begin
                dec.itype    = rv_exec_pkg::it_jalr;
                dec.alu_func = rv_exec_pkg::alu_add;         // rs1 + imm target
                dec.imm      = imm_i;
                dec.rs1      = instr.i_fmt.rs1;
                dec.rd       = instr.i_fmt.rd;
                dec.wr       = 1'b1;
            end
            default: ;                                       // CSR, system, unknown
        endcase
    end

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`default_nettype none
`include "rv_exec_config.svh"

module reg_file (
    input  wire                   clk_in,
    input  wire                   rst_n,
    input  wire  [`RV_REG_AW-1:0] rs1_addr,
    input  wire  [`RV_REG_AW-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]   rs1_val,
    output logic [`RV_XLEN-1:0]   rs2_val,
    input  wire                   wr_en,
    input  wire  [`RV_REG_AW-1:0] wr_addr,
    input  wire  [`RV_XLEN-1:0]   wr_data
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;                               // Whole file cleared
            end
        end else if (wr_en && (wr_addr != '0)) begin         // x0 never written
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_val = regs[rs1_addr];                         // Async read
    assign rs2_val = regs[rs2_addr];

    // Write address comes from the controller's result path
    a_wr_addr_known: assert property (@(posedge clk_in) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_addr));

endmodule

`default_nettype wire

/* hw/exec_unit.sv */
`default_nettype none
`include "rv_exec_config.svh"

module exec_unit (
    input  wire        [`RV_XLEN-1:0] pc,
    input  wire rv_exec_pkg::decoded_t dec,
    input  wire        [`RV_XLEN-1:0] rs1_val,
    input  wire        [`RV_XLEN-1:0] rs2_val,
    output rv_exec_pkg::exec_result_t result
);

    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] alu_out;
    logic                lt_s;
    logic                lt_u;
    logic                cond;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] pc_imm;

    assign op_b  = (dec.itype == rv_exec_pkg::it_op) ? rs2_val : dec.imm;  // Reg or imm
    assign shamt = op_b[4:0];
    assign lt_s  = $signed(rs1_val) < $signed(op_b);
    assign lt_u  = rs1_val < op_b;

    always_comb begin
        case (dec.alu_func)
            rv_exec_pkg::alu_add:  alu_out = rs1_val + op_b;
            rv_exec_pkg::alu_sub:  alu_out = rs1_val - op_b;
            rv_exec_pkg::alu_xor:  alu_out = rs1_val ^ op_b;
            rv_exec_pkg::alu_or:   alu_out = rs1_val | op_b;
            rv_exec_pkg::alu_and:  alu_out = rs1_val & op_b;
            rv_exec_pkg::alu_sll:  alu_out = rs1_val << shamt;
            rv_exec_pkg::alu_srl:  alu_out = rs1_val >> shamt;
            rv_exec_pkg::alu_sra:  alu_out = $unsigned($signed(rs1_val) >>> shamt);
            rv_exec_pkg::alu_slt:  alu_out = {{(`RV_XLEN-1){1'b0}}, lt_s};
            rv_exec_pkg::alu_sltu: alu_out = {{(`RV_XLEN-1){1'b0}}, lt_u};
            default:               alu_out = '0;             // No ALU work
        endcase
    end

    always_comb begin                                        // Branch compares rs1, rs2
        case (dec.br_func)
            rv_exec_pkg::br_eq:  cond = (rs1_val == rs2_val);
            rv_exec_pkg::br_neq: cond = (rs1_val != rs2_val);
            rv_exec_pkg::br_lt:  cond = ($signed(rs1_val) < $signed(rs2_val));
            rv_exec_pkg::br_ge:  cond = ($signed(rs1_val) >= $signed(rs2_val));
            rv_exec_pkg::br_ltu: cond = (rs1_val < rs2_val);
            rv_exec_pkg::br_geu: cond = (rs1_val >= rs2_val);
            default:             cond = 1'b0;
        endcase
    end

    assign pc_plus4 = pc + `RV_XLEN'(4);
    assign pc_imm   = pc + dec.imm;

    always_comb begin
        result         = '0;
        result.rd      = dec.rd;
        result.wr      = dec.wr && (dec.rd != '0);           // x0 writes dropped here
        result.taken   = (dec.itype == rv_exec_pkg::it_branch) && cond;
        result.illegal = (dec.itype == rv_exec_pkg::it_nop);
        result.next_pc = pc_plus4;                           // Fall through
        case (dec.itype)
            rv_exec_pkg::it_op, rv_exec_pkg::it_opimm: result.value = alu_out;
            rv_exec_pkg::it_load, rv_exec_pkg::it_store: result.value = alu_out;  // EA
            rv_exec_pkg::it_lui:   result.value = dec.imm;
            rv_exec_pkg::it_auipc: result.value = pc_imm;
            rv_exec_pkg::it_jal: begin
                result.value   = pc_plus4;                   // Link address
                result.next_pc = pc_imm;
            end
            rv_exec_pkg::it_jalr: begin
                result.value   = pc_plus4;
                result.next_pc = {alu_out[`RV_XLEN-1:1], 1'b0};  // Bit 0 cleared
            end
            rv_exec_pkg::it_branch: if (cond) result.next_pc = pc_imm;
            default: ;                                       // Illegal, value stays 0
        endcase
    end

endmodule

`default_nettype wire

/* hw/issue_ctrl.sv */
`default_nettype none
`include "rv_exec_config.svh"

module issue_ctrl (
    input  wire                            clk_in,
    input  wire                            rst_n,
    input  wire                            req,
    input  wire rv_exec_pkg::issue_req_t   req_data,
    output logic                           ack,
    output rv_exec_pkg::instr_u            cur_instr,
    input  wire rv_exec_pkg::decoded_t     dec,
    input  wire        [`RV_XLEN-1:0]      rs1_val,
    input  wire        [`RV_XLEN-1:0]      rs2_val,
    output logic       [`RV_XLEN-1:0]      ex_pc,
    output rv_exec_pkg::decoded_t          ex_dec,
    output logic       [`RV_XLEN-1:0]      ex_rs1_val,
    output logic       [`RV_XLEN-1:0]      ex_rs2_val,
    input  wire rv_exec_pkg::exec_result_t ex_result,
    output rv_exec_pkg::exec_result_t      result,
    output logic                           wr_en,
    output logic       [`RV_REG_AW-1:0]    wr_addr,
    output logic       [`RV_XLEN-1:0]      wr_data
);

    typedef enum logic [1:0] {
        st_idle,                                             // Waiting for req
        st_execute,                                          // Decode and operand read
        st_respond,                                          // Execute unit computing
        st_release                                           // Ack held until req drops
    } state_e;

    state_e                  state;
    rv_exec_pkg::issue_req_t req_q;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state  <= st_idle;
            ack    <= 1'b0;
            result <= '0;
        end else begin
            case (state)
                st_idle:    if (req) state <= st_execute;    // Cycle 0
                st_execute: state <= st_respond;             // Cycle 1
                st_respond: begin                            // Cycle 2
                    state  <= st_release;
                    ack    <= 1'b1;
                    result <= ex_result;
                end
                st_release: if (!req) begin                  // Back-pressure holds here
                    state <= st_idle;
                    ack   <= 1'b0;
                end
                default:    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin                        // Payload, no reset
        if ((state == st_idle) && req) begin
            req_q <= req_data;
        end
        if (state == st_execute) begin
            ex_pc      <= req_q.pc;
            ex_dec     <= dec;
            ex_rs1_val <= rs1_val;
            ex_rs2_val <= rs2_val;
        end
    end

    assign cur_instr = req_q.instr;

    // Write lands on the same edge that raises ack
    assign wr_en   = (state == st_respond) && ex_result.wr;
    assign wr_addr = ex_result.rd;
    assign wr_data = ex_result.value;

    a_ack_needs_req: assert property (@(posedge clk_in) disable iff (!rst_n)
        $rose(ack) |-> $past(req));

    a_req_after_ack_low: assert property (@(posedge clk_in) disable iff (!rst_n)
        $rose(req) |-> !ack);                                // New req only once ack dropped

endmodule

`default_nettype wire

/* hw/rv_exec_core.sv */
`default_nettype none
`include "rv_exec_config.svh"

module rv_exec_core (
    input  wire                            clk_in,
    input  wire                            rst_n,
    input  wire                            req,
    input  wire rv_exec_pkg::issue_req_t   req_data,
    output logic                           ack,
    output rv_exec_pkg::exec_result_t      result
);

    rv_exec_pkg::instr_u       cur_instr;
    rv_exec_pkg::decoded_t     dec;
    rv_exec_pkg::decoded_t     ex_dec;
    rv_exec_pkg::exec_result_t ex_result;
    logic [`RV_XLEN-1:0]       rs1_val;
    logic [`RV_XLEN-1:0]       rs2_val;
    logic [`RV_XLEN-1:0]       ex_pc;
    logic [`RV_XLEN-1:0]       ex_rs1_val;
    logic [`RV_XLEN-1:0]       ex_rs2_val;
    logic                      wr_en;
    logic [`RV_REG_AW-1:0]     wr_addr;
    logic [`RV_XLEN-1:0]       wr_data;

    issue_ctrl u_issue_ctrl (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .req        (req),
        .req_data   (req_data),
        .ack        (ack),
        .cur_instr  (cur_instr),
        .dec        (dec),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .ex_pc      (ex_pc),
        .ex_dec     (ex_dec),
        .ex_rs1_val (ex_rs1_val),
        .ex_rs2_val (ex_rs2_val),
        .ex_result  (ex_result),
        .result     (result),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    decode u_decode (
        .instr (cur_instr),
        .dec   (dec)
    );

    reg_file u_reg_file (
        .clk_in   (clk_in),
        .rst_n    (rst_n),
        .rs1_addr (dec.rs1),                                 // Read during execute state
        .rs2_addr (dec.rs2),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    exec_unit u_exec_unit (
        .pc      (ex_pc),
        .dec     (ex_dec),
        .rs1_val (ex_rs1_val),
        .rs2_val (ex_rs2_val),
        .result  (ex_result)
    );

endmodule

`default_nettype wire

/* testbench/tb_rv_exec_core.sv */
`default_nettype none

module tb_rv_exec_core;

    localparam int clk_period = 100;
    localparam int drv_delay  = 10;                          // Inputs change after the edge
    localparam int ack_limit  = 8;                           // Edges to wait for ack
    localparam int wd_cycles  = 20;                          // Watchdog budget per test

    logic                      clk_in;
    logic                      rst_n;
    logic                      req;
    rv_exec_pkg::issue_req_t   req_data;
    logic                      ack;
    rv_exec_pkg::exec_result_t result;

    logic [31:0]               pc_q[$];                      // Stimulus from the data file
    logic [31:0]               instr_q[$];
    rv_exec_pkg::exec_result_t exp_q[$];                     // Expected result port
    int                        n_tests;
    int                        err_count;
    int                        fail_count;
    logic [31:0]               rng_state;

    rv_exec_core u_rv_exec_core (
        .clk_in   (clk_in),
        .rst_n    (rst_n),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .result   (result)
    );

    initial begin
        clk_in = 1'b0;
        forever #(clk_period / 2) clk_in = ~clk_in;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic pick_small(output int n);                 // 0 to 3 cycles
        rng_state = xorshift32(rng_state);
        n = int'(rng_state[1:0]);
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic load_testdata(output int count);
        int                        fd;
        int                        n;
        string                     line;
        logic [31:0]               f_pc;
        logic [31:0]               f_instr;
        logic [31:0]               f_val;
        logic [31:0]               f_wr;
        logic [31:0]               f_rd;
        logic [31:0]               f_tk;
        logic [31:0]               f_npc;
        logic [31:0]               f_ill;
        rv_exec_pkg::exec_result_t e;
        count = 0;
        fd = $fopen("testbench/rv_exec_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/rv_exec_testdata.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.substr(0, 0) == "#")  // Blank or column notes
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                        f_pc, f_instr, f_val, f_wr, f_rd, f_tk, f_npc, f_ill);
            if (n != 8)
                continue;
            e         = '0;
            e.rd      = f_rd[4:0];
            e.value   = f_val;
            e.wr      = f_wr[0];
            e.taken   = f_tk[0];
            e.next_pc = f_npc;
            e.illegal = f_ill[0];
            pc_q.push_back(f_pc);
            instr_q.push_back(f_instr);
            exp_q.push_back(e);
            count++;
        end
        $fclose(fd);
    endtask

    task automatic run_one(input int idx);
        int                        gap;
        int                        hold;
        int                        cycles;
        int                        errs_before;
        rv_exec_pkg::exec_result_t got;
        rv_exec_pkg::exec_result_t exp;
        exp         = exp_q[idx];
        errs_before = err_count;
        pick_small(gap);
        pick_small(hold);
        repeat (gap) begin                                   // Idle gap before req
            @(posedge clk_in);
            #drv_delay;
        end
        req_data.pc    = pc_q[idx];
        req_data.instr = instr_q[idx];
        req            = 1'b1;
        cycles         = 0;
        do begin
            @(posedge clk_in);
            #drv_delay;
            cycles++;
        end while (!ack && cycles < ack_limit);
        if (!ack) begin
            $display("test %0d: ack never rose after req was raised", idx);
            err_count++;
        end else begin
            if (cycles != 3) begin                           // First edge samples req
                $display("test %0d: ack rose %0d cycles after req was sampled, not 2",
                         idx, cycles - 1);
                err_count++;
            end
            got = result;
            compare_field("value", got.value, exp.value);
            compare_field("wr", got.wr, exp.wr);
            compare_field("rd", got.rd, exp.rd);
            compare_field("taken", got.taken, exp.taken);
            compare_field("next_pc", got.next_pc, exp.next_pc);
            compare_field("illegal", got.illegal, exp.illegal);
            repeat (hold) begin                              // Back-pressure
                @(posedge clk_in);
                #drv_delay;
                if (ack !== 1'b1 || result !== got) begin
                    $display("test %0d: ack or result changed while req was held", idx);
                    err_count++;
                end
            end
        end
        req = 1'b0;
        @(posedge clk_in);
        #drv_delay;
        if (ack !== 1'b0) begin
            $display("test %0d: ack still high one edge after req dropped", idx);
            err_count++;
        end
        if (err_count == errs_before) begin
            $display("test %0d pc %h instr %h passed", idx, pc_q[idx], instr_q[idx]);
        end else begin
            $display("test %0d pc %h instr %h failed", idx, pc_q[idx], instr_q[idx]);
            fail_count++;
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        req        = 1'b0;
        req_data   = '0;
        err_count  = 0;
        fail_count = 0;
        rng_state  = 32'd95521;
        load_testdata(n_tests);
        if (n_tests == 0) begin
            $display("no test vectors were read from the testdata file");
            err_count++;
        end else begin
            repeat (3) @(posedge clk_in);                    // Reset for 3 cycles
            #drv_delay;
            rst_n = 1'b1;
            if (ack !== 1'b0 || result !== '0) begin
                $display("ERR %0t: ack or result not cleared by reset", $time);
                err_count++;
            end
            for (int i = 0; i < n_tests; i++) begin
                run_one(i);
            end
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 n_tests, n_tests - fail_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin                                            // Watchdog
        wait (n_tests > 0);
        #(n_tests * wd_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the DUT stopped responding",
                 n_tests * wd_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/rv_exec_testdata.txt */
# Columns in hex: pc instr value wr rd taken next_pc illegal
# Registers start at zero after reset and carry over from line to line
00000100 00500093 00000005 1 01 0 00000104 0
00000104 FFD00113 FFFFFFFD 1 02 0 00000108 0
00000108 123451B7 12345000 1 03 0 0000010C 0
0000010C 00001217 0000110C 1 04 0 00000110 0
00000110 002082B3 00000002 1 05 0 00000114 0
00000114 40208333 00000008 1 06 0 00000118 0
00000118 0030C3B3 12345005 1 07 0 0000011C 0
0000011C 00316433 FFFFFFFD 1 08 0 00000120 0
00000120 003174B3 12345000 1 09 0 00000124 0
00000124 00119533 468A0000 1 0A 0 00000128 0
00000128 001155B3 07FFFFFF 1 0B 0 0000012C 0
0000012C 40115633 FFFFFFFF 1 0C 0 00000130 0
00000130 001126B3 00000001 1 0D 0 00000134 0
00000134 00113733 00000000 1 0E 0 00000138 0
00000138 00108863 00000000 0 00 1 00000148 0
0000013C 00109863 00000000 0 00 0 00000140 0
00000140 FE114CE3 00000000 0 00 1 00000138 0
00000144 00115463 00000000 0 00 0 00000148 0
00000148 00116463 00000000 0 00 0 0000014C 0
0000014C 00117463 00000000 0 00 1 00000154 0
00000150 020007EF 00000154 1 0F 0 00000170 0
00000154 00718867 00000158 1 10 0 12345006 0
00000158 00C1A883 1234500C 0 11 0 0000015C 0
0000015C FE112E23 FFFFFFF9 0 00 0 00000160 0
00000160 00000073 00000000 0 00 0 00000164 1
00000164 02A00013 0000002A 0 00 0 00000168 0
00000168 00100933 00000005 1 12 0 0000016C 0
0000016C 006289B3 0000000A 1 13 0 00000170 0
00000170 01078A33 000002AC 1 14 0 00000174 0

/* tb.f */
+incdir+hw
hw/rv_exec_pkg.sv
hw/decode.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/issue_ctrl.sv
hw/rv_exec_core.sv
testbench/tb_rv_exec_core.sv

/* Bender.yml */
package:
  name: rv_exec_core

export_include_dirs:
  - hw

sources:
  - hw/rv_exec_pkg.sv
  - hw/decode.sv
  - hw/reg_file.sv
  - hw/exec_unit.sv
  - hw/issue_ctrl.sv
  - hw/rv_exec_core.sv
  - target: test
    files:
      - testbench/tb_rv_exec_core.sv
